// ==== Makefile ====
SIM  = obj_dir/Vtb_lsu
SRCS = $(shell cat sim.f)

all: run

$(SIM): sim.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module tb_lsu -f sim.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// ==== load_fu.sv ====
module load_fu (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     issue_req,
    input  logic [lsu_pkg::xlen-1:0] issue_inst,
    input  logic [lsu_pkg::xlen-1:0] issue_rs1,
    input  lsu_pkg::rob_tag_t        issue_tag,
    output logic                     issue_ack,
    mem_req_if.requester             mem,
    cpl_if.requester                 cpl
);
    import lsu_pkg::*;

    typedef enum logic [2:0] {
        idle,
        issue_done,
        mem_access,
        mem_release,
        complete,
        cpl_release
    } state_e;

    state_e          state;
    logic            issue_ack_q;
    logic            mem_req_q;
    logic            cpl_req_q;

    logic [i_imm_w-1:0] i_imm;
    logic [xlen-1:0]    addr_next;
    logic [xlen-1:0]    addr_q;
    load_funct3_e       funct3_q;
    rob_tag_t           tag_q;
    logic [xlen-1:0]    rdata_q;
    logic [7:0]         byte_sel;
    logic [15:0]        half_sel;
    logic [xlen-1:0]    load_value;

    // effective address, rs1 + sext(inst[31:20])
    assign i_imm     = issue_inst[31:20];
    assign addr_next = issue_rs1 + {{(xlen - i_imm_w){i_imm[i_imm_w-1]}}, i_imm};

    always_ff @(posedge clock) begin
        if (reset) begin
            state       <= idle;
            issue_ack_q <= 1'b0;
            mem_req_q   <= 1'b0;
            cpl_req_q   <= 1'b0;
        end else begin
            case (state)
                idle: if (issue_req) begin
                    issue_ack_q <= 1'b1;
                    state       <= issue_done;
                end
                issue_done: if (!issue_req) begin
                    issue_ack_q <= 1'b0;
                    state       <= mem_access;
                end
                mem_access: begin
                    mem_req_q <= 1'b1;  // rises one cycle after the issue handshake
                    if (mem_req_q && mem.ack) begin
                        mem_req_q <= 1'b0;
                        state     <= mem_release;
                    end
                end
                mem_release: if (!mem.ack) begin
                    cpl_req_q <= 1'b1;
                    state     <= complete;
                end
                complete: if (cpl.ack) begin
                    cpl_req_q <= 1'b0;
                    state     <= cpl_release;
                end
                cpl_release: if (!cpl.ack) state <= idle;
                default: state <= idle;
            endcase
        end
    end

    // operation payload
    always_ff @(posedge clock) begin
        if (state == idle && issue_req) begin
            addr_q   <= addr_next;
            funct3_q <= load_funct3_e'(issue_inst[14:12]);
            tag_q    <= issue_tag;
        end
        if (state == mem_access && mem_req_q && mem.ack) rdata_q <= mem.rdata;
    end

    // lane select by low address bits
    assign byte_sel = rdata_q[{addr_q[1:0], 3'b000} +: 8];
    assign half_sel = addr_q[1] ? rdata_q[31:16] : rdata_q[15:0];

    always_comb begin
        case (funct3_q)
            lb:      load_value = {{(xlen - 8){byte_sel[7]}}, byte_sel};
            lh:      load_value = {{(xlen - 16){half_sel[15]}}, half_sel};
            lbu:     load_value = {{(xlen - 8){1'b0}}, byte_sel};
            lhu:     load_value = {{(xlen - 16){1'b0}}, half_sel};
            default: load_value = rdata_q;  // lw
        endcase
    end

    assign issue_ack = issue_ack_q;

    assign mem.req   = mem_req_q;
    assign mem.write = 1'b0;      // read only
    assign mem.addr  = addr_q;
    assign mem.wdata = '0;
    assign mem.wstrb = 4'b0000;

    assign cpl.req   = cpl_req_q;
    assign cpl.tag   = tag_q;
    assign cpl.value = load_value;
    assign cpl.store = 1'b0;

endmodule

// ==== lsu_arbiter.sv ====
module lsu_arbiter #(
    parameter int mem_words = 64
) (
    input  logic                     clock,
    input  logic                     reset,
    mem_req_if.responder             ld_mem,
    mem_req_if.responder             st_mem,
    cpl_if.responder                 ld_cpl,
    cpl_if.responder                 st_cpl,
    output logic                     cdb_req,
    output lsu_pkg::rob_tag_t        cdb_tag,
    output logic [lsu_pkg::xlen-1:0] cdb_value,
    output logic                     cdb_store,
    input  logic                     cdb_ack
);
    import lsu_pkg::*;

    localparam int aw = $clog2(mem_words);

    typedef enum logic {m_idle, m_ack} mem_state_e;
    typedef enum logic [1:0] {c_idle, c_bus, c_release} cpl_state_e;

    logic [xlen-1:0] mem_array [mem_words];
    logic [aw-1:0]   clr_idx;
    logic            clr_busy;

    mem_state_e      mstate;
    logic            mem_last_st;  // store was served last
    logic            mem_sel_st;
    logic            pick_mem_st;
    logic            mem_grant;
    logic            ld_mem_ack_q;
    logic            st_mem_ack_q;
    logic [aw-1:0]   sel_idx;
    logic [xlen-1:0] sel_wdata;
    logic [3:0]      sel_wstrb;
    logic            sel_write;
    logic [xlen-1:0] rdata_q;

    cpl_state_e      cstate;
    logic            cpl_last_st;
    logic            cpl_sel_st;
    logic            pick_cpl_st;
    logic            cpl_sel_req;
    logic            cpl_sel_ack;
    logic            ld_cpl_ack_q;
    logic            st_cpl_ack_q;
    logic            cdb_req_q;

    // zero the array once after reset, no grant until done
    always_ff @(posedge clock) begin
        if (reset) begin
            clr_busy <= 1'b1;
            clr_idx  <= '0;
        end else if (clr_busy) begin
            clr_idx <= clr_idx + 1'b1;
            if (&clr_idx) clr_busy <= 1'b0;
        end
    end

    // round robin, the other unit wins a tie
    assign pick_mem_st = st_mem.req && (!ld_mem.req || !mem_last_st);
    assign mem_grant   = (mstate == m_idle) && !clr_busy && (ld_mem.req || st_mem.req);

    assign sel_write = pick_mem_st ? st_mem.write : ld_mem.write;
    assign sel_wdata = pick_mem_st ? st_mem.wdata : ld_mem.wdata;
    assign sel_wstrb = pick_mem_st ? st_mem.wstrb : ld_mem.wstrb;
    assign sel_idx   = pick_mem_st ? st_mem.addr[aw+1:2] : ld_mem.addr[aw+1:2];

    always_ff @(posedge clock) begin
        if (clr_busy) begin
            mem_array[clr_idx] <= '0;
        end else if (mem_grant) begin
            if (sel_write) begin
                for (int i = 0; i < 4; i++) begin
                    if (sel_wstrb[i]) mem_array[sel_idx][8*i +: 8] <= sel_wdata[8*i +: 8];
                end
            end else begin
                rdata_q <= mem_array[sel_idx];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            mstate       <= m_idle;
            mem_last_st  <= 1'b0;
            mem_sel_st   <= 1'b0;
            ld_mem_ack_q <= 1'b0;
            st_mem_ack_q <= 1'b0;
        end else begin
            case (mstate)
                m_idle: if (mem_grant) begin
                    ld_mem_ack_q <= !pick_mem_st;
                    st_mem_ack_q <= pick_mem_st;
                    mem_sel_st   <= pick_mem_st;
                    mem_last_st  <= pick_mem_st;
                    mstate       <= m_ack;
                end
                m_ack: if (!(mem_sel_st ? st_mem.req : ld_mem.req)) begin
                    ld_mem_ack_q <= 1'b0;
                    st_mem_ack_q <= 1'b0;
                    mstate       <= m_idle;
                end
                default: mstate <= m_idle;
            endcase
        end
    end

    // completion merge, independent of the memory side
    assign pick_cpl_st = st_cpl.req && (!ld_cpl.req || !cpl_last_st);
    assign cpl_sel_req = cpl_sel_st ? st_cpl.req : ld_cpl.req;
    assign cpl_sel_ack = cpl_sel_st ? st_cpl_ack_q : ld_cpl_ack_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            cstate       <= c_idle;
            cpl_last_st  <= 1'b0;
            cpl_sel_st   <= 1'b0;
            ld_cpl_ack_q <= 1'b0;
            st_cpl_ack_q <= 1'b0;
            cdb_req_q    <= 1'b0;
        end else begin
            case (cstate)
                c_idle: if (ld_cpl.req || st_cpl.req) begin
                    cdb_req_q   <= 1'b1;
                    cpl_sel_st  <= pick_cpl_st;
                    cpl_last_st <= pick_cpl_st;
                    cstate      <= c_bus;
                end
                c_bus: if (cdb_ack) begin
                    cdb_req_q    <= 1'b0;
                    ld_cpl_ack_q <= !cpl_sel_st;  // pass the ack back to the unit
                    st_cpl_ack_q <= cpl_sel_st;
                    cstate       <= c_release;
                end
                c_release: begin
                    if (!cpl_sel_req) begin
                        ld_cpl_ack_q <= 1'b0;
                        st_cpl_ack_q <= 1'b0;
                    end
                    if (!cdb_ack && (!cpl_sel_req || !cpl_sel_ack)) cstate <= c_idle;
                end
                default: cstate <= c_idle;
            endcase
        end
    end

    // cdb fields held from grant until the next one
    always_ff @(posedge clock) begin
        if (cstate == c_idle && (ld_cpl.req || st_cpl.req)) begin
            cdb_tag   <= pick_cpl_st ? st_cpl.tag : ld_cpl.tag;
            cdb_value <= pick_cpl_st ? st_cpl.value : ld_cpl.value;
            cdb_store <= pick_cpl_st ? st_cpl.store : ld_cpl.store;
        end
    end

    assign ld_mem.ack   = ld_mem_ack_q;
    assign st_mem.ack   = st_mem_ack_q;
    assign ld_mem.rdata = rdata_q;
    assign st_mem.rdata = rdata_q;
    assign ld_cpl.ack   = ld_cpl_ack_q;
    assign st_cpl.ack   = st_cpl_ack_q;
    assign cdb_req      = cdb_req_q;

endmodule

// ==== lsu_if.sv ====
// one data memory access, four-phase req/ack
interface mem_req_if;
    import lsu_pkg::*;

    logic            req;
    logic            write;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] wdata;
    logic [3:0]      wstrb;  // byte lanes to write
    logic            ack;
    logic [xlen-1:0] rdata;  // valid while ack is high on a read

    modport requester (
        output req, write, addr, wdata, wstrb,
        input  ack, rdata
    );

    modport responder (
        input  req, write, addr, wdata, wstrb,
        output ack, rdata
    );
endinterface

// unit result toward the completion bus
interface cpl_if;
    import lsu_pkg::*;

    logic            req;
    rob_tag_t        tag;
    logic [xlen-1:0] value;
    logic            store;  // set for store completions
    logic            ack;

    modport requester (
        output req, tag, value, store,
        input  ack
    );

    modport responder (
        input  req, tag, value, store,
        output ack
    );
endinterface

// ==== lsu_pkg.sv ====
package lsu_pkg;

    // data and address width
    localparam int xlen = 32;

    // immediate field widths in the instruction word
    localparam int i_imm_w = 12;
    localparam int s_imm_w = 12;

    // reorder buffer entry
    typedef logic [4:0] rob_tag_t;

    // load sizes, encoded as in funct3
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_e;

    // store sizes, encoded as in funct3
    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_e;

endpackage

// ==== lsu_props.sv ====
module lsu_props (
    input logic                       clock,
    input logic                       reset,
    input logic                       ld_mem_req,
    input logic                       ld_mem_ack,
    input logic                       st_mem_req,
    input logic                       st_mem_ack,
    input logic                       ld_cpl_req,
    input logic                       ld_cpl_ack,
    input logic                       st_cpl_req,
    input logic                       st_cpl_ack,
    input logic                       cdb_req,
    input logic                       cdb_ack,
    input logic [lsu_pkg::xlen+5:0]   cdb_fields  // tag, value, store
);

    // one memory grant at a time
    one_mem_ack: assert property (@(posedge clock) disable iff (reset)
        !(ld_mem_ack && st_mem_ack)) else $error("both memory acks high together");

    cdb_held: assert property (@(posedge clock) disable iff (reset)
        cdb_req && !cdb_ack |=> cdb_req) else $error("cdb_req dropped before cdb_ack");

    cdb_stable: assert property (@(posedge clock) disable iff (reset)
        cdb_req && $past(cdb_req) |-> $stable(cdb_fields))
        else $error("cdb fields changed while cdb_req high");

    // an ack may only rise in answer to a live req
    ld_mem_ack_req: assert property (@(posedge clock) disable iff (reset)
        $rose(ld_mem_ack) |-> ld_mem_req) else $error("load memory ack without req");
    st_mem_ack_req: assert property (@(posedge clock) disable iff (reset)
        $rose(st_mem_ack) |-> st_mem_req) else $error("store memory ack without req");
    ld_cpl_ack_req: assert property (@(posedge clock) disable iff (reset)
        $rose(ld_cpl_ack) |-> ld_cpl_req) else $error("load completion ack without req");
    st_cpl_ack_req: assert property (@(posedge clock) disable iff (reset)
        $rose(st_cpl_ack) |-> st_cpl_req) else $error("store completion ack without req");

endmodule

bind lsu_arbiter lsu_props u_lsu_props (
    .clock      (clock),
    .reset      (reset),
    .ld_mem_req (ld_mem.req),
    .ld_mem_ack (ld_mem.ack),
    .st_mem_req (st_mem.req),
    .st_mem_ack (st_mem.ack),
    .ld_cpl_req (ld_cpl.req),
    .ld_cpl_ack (ld_cpl.ack),
    .st_cpl_req (st_cpl.req),
    .st_cpl_ack (st_cpl.ack),
    .cdb_req    (cdb_req),
    .cdb_ack    (cdb_ack),
    .cdb_fields ({cdb_tag, cdb_value, cdb_store})
);

// ==== lsu_top.sv ====
module lsu_top #(
    parameter int mem_words = 64
) (
    input  logic                     clock,
    input  logic                     reset,

    // load issue
    input  logic                     ld_req,
    input  logic [lsu_pkg::xlen-1:0] ld_inst,
    input  logic [lsu_pkg::xlen-1:0] ld_rs1,
    input  lsu_pkg::rob_tag_t        ld_tag,
    output logic                     ld_ack,

    // store issue
    input  logic                     st_req,
    input  logic [lsu_pkg::xlen-1:0] st_inst,
    input  logic [lsu_pkg::xlen-1:0] st_rs1,
    input  logic [lsu_pkg::xlen-1:0] st_rs2,
    input  lsu_pkg::rob_tag_t        st_tag,
    output logic                     st_ack,

    // completion bus toward the ROB
    output logic                     cdb_req,
    output lsu_pkg::rob_tag_t        cdb_tag,
    output logic [lsu_pkg::xlen-1:0] cdb_value,
    output logic                     cdb_store,
    input  logic                     cdb_ack
);

    mem_req_if ld_mem_bus ();
    mem_req_if st_mem_bus ();
    cpl_if     ld_cpl_bus ();
    cpl_if     st_cpl_bus ();

    load_fu u_load_fu (
        .clock      (clock),
        .reset      (reset),
        .issue_req  (ld_req),
        .issue_inst (ld_inst),
        .issue_rs1  (ld_rs1),
        .issue_tag  (ld_tag),
        .issue_ack  (ld_ack),
        .mem        (ld_mem_bus.requester),
        .cpl        (ld_cpl_bus.requester)
    );

    store_fu u_store_fu (
        .clock      (clock),
        .reset      (reset),
        .issue_req  (st_req),
        .issue_inst (st_inst),
        .issue_rs1  (st_rs1),
        .issue_rs2  (st_rs2),
        .issue_tag  (st_tag),
        .issue_ack  (st_ack),
        .mem        (st_mem_bus.requester),
        .cpl        (st_cpl_bus.requester)
    );

    lsu_arbiter #(
        .mem_words (mem_words)
    ) u_lsu_arbiter (
        .clock     (clock),
        .reset     (reset),
        .ld_mem    (ld_mem_bus.responder),
        .st_mem    (st_mem_bus.responder),
        .ld_cpl    (ld_cpl_bus.responder),
        .st_cpl    (st_cpl_bus.responder),
        .cdb_req   (cdb_req),
        .cdb_tag   (cdb_tag),
        .cdb_value (cdb_value),
        .cdb_store (cdb_store),
        .cdb_ack   (cdb_ack)
    );

endmodule

// ==== sim.f ====
lsu_pkg.sv
lsu_if.sv
load_fu.sv
store_fu.sv
lsu_arbiter.sv
lsu_top.sv
lsu_props.sv
tb_lsu.sv

// ==== store_fu.sv ====
module store_fu (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     issue_req,
    input  logic [lsu_pkg::xlen-1:0] issue_inst,
    input  logic [lsu_pkg::xlen-1:0] issue_rs1,
    input  logic [lsu_pkg::xlen-1:0] issue_rs2,
    input  lsu_pkg::rob_tag_t        issue_tag,
    output logic                     issue_ack,
    mem_req_if.requester             mem,
    cpl_if.requester                 cpl
);
    import lsu_pkg::*;

    typedef enum logic [2:0] {
        idle,
        issue_done,
        mem_access,
        mem_release,
        complete,
        cpl_release
    } state_e;

    state_e             state;
    logic               issue_ack_q;
    logic               mem_req_q;
    logic               cpl_req_q;

    logic [s_imm_w-1:0] s_imm;
    logic [xlen-1:0]    addr_next;
    store_funct3_e      funct3;
    logic [xlen-1:0]    wdata_next;
    logic [3:0]         wstrb_next;
    logic [xlen-1:0]    addr_q;
    logic [xlen-1:0]    wdata_q;
    logic [3:0]         wstrb_q;
    rob_tag_t           tag_q;

    // S immediate is split across inst[31:25] and inst[11:7]
    assign s_imm     = {issue_inst[31:25], issue_inst[11:7]};
    assign addr_next = issue_rs1 + {{(xlen - s_imm_w){s_imm[s_imm_w-1]}}, s_imm};
    assign funct3    = store_funct3_e'(issue_inst[14:12]);

    // replicate rs2 over the lanes, the mask picks the live ones
    always_comb begin
        case (funct3)
            sb: begin
                wdata_next = {4{issue_rs2[7:0]}};
                wstrb_next = 4'b0001 << addr_next[1:0];
            end
            sh: begin
                wdata_next = {2{issue_rs2[15:0]}};
                wstrb_next = addr_next[1] ? 4'b1100 : 4'b0011;
            end
            sw: begin
                wdata_next = issue_rs2;
                wstrb_next = 4'b1111;
            end
            default: begin
                wdata_next = issue_rs2;
                wstrb_next = 4'b0000;  // unknown size writes nothing
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state       <= idle;
            issue_ack_q <= 1'b0;
            mem_req_q   <= 1'b0;
            cpl_req_q   <= 1'b0;
        end else begin
            case (state)
                idle: if (issue_req) begin
                    issue_ack_q <= 1'b1;
                    state       <= issue_done;
                end
                issue_done: if (!issue_req) begin
                    issue_ack_q <= 1'b0;
                    state       <= mem_access;
                end
                mem_access: begin
                    mem_req_q <= 1'b1;
                    if (mem_req_q && mem.ack) begin
                        mem_req_q <= 1'b0;
                        state     <= mem_release;
                    end
                end
                mem_release: if (!mem.ack) begin
                    cpl_req_q <= 1'b1;
                    state     <= complete;
                end
                complete: if (cpl.ack) begin
                    cpl_req_q <= 1'b0;
                    state     <= cpl_release;
                end
                cpl_release: if (!cpl.ack) state <= idle;
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == idle && issue_req) begin
            addr_q  <= addr_next;
            wdata_q <= wdata_next;
            wstrb_q <= wstrb_next;
            tag_q   <= issue_tag;
        end
    end

    assign issue_ack = issue_ack_q;

    assign mem.req   = mem_req_q;
    assign mem.write = 1'b1;
    assign mem.addr  = addr_q;
    assign mem.wdata = wdata_q;
    assign mem.wstrb = wstrb_q;

    assign cpl.req   = cpl_req_q;
    assign cpl.tag   = tag_q;
    assign cpl.value = '0;  // stores carry no result
    assign cpl.store = 1'b1;

endmodule

// ==== tb_lsu.sv ====
module tb_lsu;
    import lsu_pkg::*;

    localparam int mem_words  = 64;
    localparam int random_ops = 40;  // per unit

    logic            clock;
    logic            reset;
    logic            ld_req;
    logic [xlen-1:0] ld_inst;
    logic [xlen-1:0] ld_rs1;
    rob_tag_t        ld_tag;
    logic            ld_ack;
    logic            st_req;
    logic [xlen-1:0] st_inst;
    logic [xlen-1:0] st_rs1;
    logic [xlen-1:0] st_rs2;
    rob_tag_t        st_tag;
    logic            st_ack;
    logic            cdb_req;
    rob_tag_t        cdb_tag;
    logic [xlen-1:0] cdb_value;
    logic            cdb_store;
    logic            cdb_ack;

    // reference model of the data memory
    logic [xlen-1:0] model_mem [mem_words];
    int              word_loads [mem_words];   // loads in flight per word
    int              word_stores [mem_words];

    // expected completion per tag
    logic            exp_valid [32];
    logic            exp_store [32];
    logic [xlen-1:0] exp_value [32];
    int              exp_word [32];

    int         ld_pending = 0;
    int         st_pending = 0;
    int         issued = 0;
    int         completed = 0;
    int         checks = 0;
    int         errors = 0;
    int         test_checks = 0;
    int         test_errors = 0;
    int         cycles = 0;
    logic [3:0] ld_seq = '0;
    logic [3:0] st_seq = '0;

    lsu_top #(.mem_words(mem_words)) u_lsu_top (.*);

    always #4 clock = ~clock;

    task automatic compare(input logic [xlen-1:0] actual, input logic [xlen-1:0] expected,
                           input string what);
        checks++;
        if (actual !== expected) begin
            $display("mismatch at %0t: %s, got %h, expected %h", $time, what, actual, expected);
            errors++;
        end
    endtask

    // RV32 encodings with rs1 = x1, rs2 = x2, rd = x2
    function automatic logic [xlen-1:0] load_inst(input logic [11:0] imm, input logic [2:0] f3);
        return {imm, 5'd1, f3, 5'd2, 7'b0000011};
    endfunction

    function automatic logic [xlen-1:0] store_inst(input logic [11:0] imm, input logic [2:0] f3);
        return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], 7'b0100011};
    endfunction

    // rs1 so that rs1 + imm lands on the byte, plus whole laps of the memory
    function automatic logic [xlen-1:0] base_for(input int widx, input int off,
                                                 input logic [11:0] imm, input logic [23:0] wrap);
        logic [xlen-1:0] addr;
        addr = widx * 4 + off;
        return addr - {{20{imm[11]}}, imm} + wrap * (4 * mem_words);
    endfunction

    function automatic logic [xlen-1:0] expected_load(input int widx, input int off,
                                                      input load_funct3_e f3);
        logic [xlen-1:0] w;
        w = model_mem[widx] >> (8 * off);
        case (f3)
            lb:      return {{24{w[7]}}, w[7:0]};
            lh:      return {{16{w[15]}}, w[15:0]};
            lbu:     return {24'h0, w[7:0]};
            lhu:     return {16'h0, w[15:0]};
            default: return w;
        endcase
    endfunction

    task automatic apply_store(input int widx, input int off, input store_funct3_e f3,
                               input logic [xlen-1:0] data);
        case (f3)
            sb:      model_mem[widx][8*off +: 8] = data[7:0];
            sh:      model_mem[widx][8*off +: 16] = data[15:0];
            default: model_mem[widx] = data;
        endcase
    endtask

    task automatic do_load(input int widx, input int off, input load_funct3_e f3,
                           input logic [11:0] imm, input logic [23:0] wrap);
        rob_tag_t        tag;
        logic [xlen-1:0] value;
        tag = {1'b0, ld_seq};
        ld_seq = ld_seq + 1'b1;
        word_loads[widx]++;
        value = expected_load(widx, off, f3);  // no store to this word in flight
        issued++;
        @(posedge clock);
        ld_req  <= 1'b1;
        ld_inst <= load_inst(imm, f3);
        ld_rs1  <= base_for(widx, off, imm, wrap);
        ld_tag  <= tag;
        do @(posedge clock); while (!ld_ack);
        compare(ld_pending, 0, "load accepted while previous load incomplete");
        exp_valid[tag] = 1'b1;
        exp_store[tag] = 1'b0;
        exp_value[tag] = value;
        exp_word[tag]  = widx;
        ld_pending++;
        ld_req <= 1'b0;
        do @(posedge clock); while (ld_ack);
    endtask

    task automatic do_store(input int widx, input int off, input store_funct3_e f3,
                            input logic [11:0] imm, input logic [23:0] wrap,
                            input logic [xlen-1:0] data);
        rob_tag_t tag;
        tag = {1'b1, st_seq};
        st_seq = st_seq + 1'b1;
        word_stores[widx]++;
        issued++;
        @(posedge clock);
        st_req  <= 1'b1;
        st_inst <= store_inst(imm, f3);
        st_rs1  <= base_for(widx, off, imm, wrap);
        st_rs2  <= data;
        st_tag  <= tag;
        do @(posedge clock); while (!st_ack);
        compare(st_pending, 0, "store accepted while previous store incomplete");
        apply_store(widx, off, f3, data);
        exp_valid[tag] = 1'b1;
        exp_store[tag] = 1'b1;
        exp_value[tag] = '0;
        exp_word[tag]  = widx;
        st_pending++;
        st_req <= 1'b0;
        do @(posedge clock); while (st_ack);
    endtask

    task automatic take_completion();
        rob_tag_t tag;
        tag = cdb_tag;
        if (!exp_valid[tag]) begin
            $display("error at %0t: completion for tag %0d, which is not in flight", $time, tag);
            errors++;
        end else begin
            compare(cdb_store, exp_store[tag], $sformatf("store flag of tag %0d", tag));
            compare(cdb_value, exp_value[tag], $sformatf("value of tag %0d", tag));
            exp_valid[tag] = 1'b0;
            if (exp_store[tag]) begin
                st_pending--;
                word_stores[exp_word[tag]]--;
            end else begin
                ld_pending--;
                word_loads[exp_word[tag]]--;
            end
            completed++;
        end
    endtask

    // wait until every accepted operation has completed
    task automatic drain();
        while (ld_pending != 0 || st_pending != 0) @(posedge clock);
    endtask

    task automatic end_test(input string name);
        $display("%s: %0d checks, %0d errors", name, checks - test_checks, errors - test_errors);
        test_checks = checks;
        test_errors = errors;
    endtask

    task automatic random_loads(input int count);
        int widx;
        int off;
        int raw;
        repeat (count) begin
            do raw = $urandom_range(5, 0); while (raw == 3);  // funct3 of a load
            off = $urandom_range(3, 0);
            off = off - off % (1 << (raw % 4));  // aligned to the size
            do begin
                widx = $urandom_range(mem_words - 1, 0);
            end while (word_stores[widx] != 0);
            do_load(widx, off, load_funct3_e'(raw), 12'($urandom), 24'($urandom));
        end
    endtask

    task automatic random_stores(input int count);
        int widx;
        int off;
        int raw;
        repeat (count) begin
            raw = $urandom_range(2, 0);
            off = $urandom_range(3, 0);
            off = off - off % (1 << raw);
            do begin
                widx = $urandom_range(mem_words - 1, 0);
            end while (word_loads[widx] != 0);
            do_store(widx, off, store_funct3_e'(raw), 12'($urandom), 24'($urandom), $urandom);
        end
    endtask

    // ROB side acks each completion after 0 to 3 cycles
    initial begin : cdb_responder
        int wait_cycles;
        wait_cycles = -1;
        wait (reset == 1'b0);
        forever begin
            @(posedge clock);
            if (cdb_req && !cdb_ack) begin
                if (wait_cycles < 0) wait_cycles = $urandom_range(3, 0);
                if (wait_cycles == 0) begin
                    take_completion();
                    cdb_ack <= 1'b1;
                    wait_cycles = -1;
                end else begin
                    wait_cycles--;
                end
            end else if (!cdb_req && cdb_ack) begin
                cdb_ack <= 1'b0;
            end
        end
    end

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles > 40 * issued + 200) begin
            $display("timeout: run stopped after %0d cycles, %0d operations issued",
                     cycles, issued);
            $display("test failed");
            $finish;
        end
    end

    initial begin
        clock   = 1'b0;
        reset   = 1'b1;
        ld_req  = 1'b0;
        ld_inst = '0;
        ld_rs1  = '0;
        ld_tag  = '0;
        st_req  = 1'b0;
        st_inst = '0;
        st_rs1  = '0;
        st_rs2  = '0;
        st_tag  = '0;
        cdb_ack = 1'b0;
        for (int i = 0; i < mem_words; i++) begin
            model_mem[i]   = '0;
            word_loads[i]  = 0;
            word_stores[i] = 0;
        end
        foreach (exp_valid[i]) exp_valid[i] = 1'b0;
        void'($urandom(84961));
        repeat (3) @(posedge clock);
        reset <= 1'b0;

        repeat (2) @(posedge clock);
        compare(ld_ack, 1'b0, "ld_ack after reset");
        compare(st_ack, 1'b0, "st_ack after reset");
        compare(cdb_req, 1'b0, "cdb_req after reset");
        end_test("reset_state");

        for (int i = 0; i < 8; i++) do_store(i, 0, sw, 12'($urandom_range(2047, 0)), 0, $urandom);
        drain();
        for (int i = 0; i < 8; i++) do_load(i, 0, lw, 12'($urandom_range(2047, 0)), 0);
        drain();
        end_test("word_store_load");

        do_store(10, 0, sw, 12'h010, 0, 32'h8a7f_c301);  // mixed sign bits per lane
        drain();
        for (int off = 0; off < 4; off++) begin
            do_load(10, off, lb, 12'h020, 0);
            do_load(10, off, lbu, 12'h7f0, 0);
        end
        for (int off = 0; off < 4; off += 2) begin
            do_load(10, off, lh, 12'h004, 0);
            do_load(10, off, lhu, 12'h100, 0);
        end
        drain();
        end_test("sub_word_loads");

        do_store(20, 0, sw, 12'h000, 0, 32'h1122_3344);
        do_store(21, 0, sw, 12'h008, 0, 32'h5566_7788);
        drain();
        do_store(20, 1, sb, 12'h00c, 0, 32'hffff_ffab);
        do_store(21, 2, sh, 12'h010, 0, 32'h1234_beef);
        drain();
        do_load(20, 0, lw, 12'h000, 0);
        do_load(21, 0, lw, 12'h000, 0);
        drain();
        end_test("partial_stores");

        do_store(1, 0, sw, 12'hfe0, 24'hffffff, 32'hcafe_f00d);   // rs1 + imm below zero
        do_store(62, 0, sw, 12'hffc, 24'hffffff, 32'h0bad_cafe);
        do_store(0, 2, sh, 12'h800, 0, 32'h0000_a55a);
        drain();
        do_load(1, 0, lw, 12'h040, 0);
        do_load(62, 0, lw, 12'h004, 0);
        do_load(0, 0, lw, 12'h7ff, 0);
        drain();
        end_test("negative_imm");

        fork
            random_loads(random_ops);
            random_stores(random_ops);
        join
        drain();
        end_test("random_mixed");

        for (int i = 0; i < mem_words; i++) do_load(i, 0, lw, 12'($urandom), 24'($urandom));
        drain();
        end_test("memory_sweep");

        $display("summary: %0d checks, %0d errors, %0d issued, %0d completed",
                 checks, errors, issued, completed);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
